// File: bench/backend_tb.sv
// execute back end testbench
`timescale 1ns/1ns
`default_nettype none

module backend_tb;

	localparam int ADDR_WIDTH = 12;
	localparam int NUM_OPS = 64;
	localparam int CYCLE_LIMIT = 40 * NUM_OPS + 8;
	localparam logic [31:0] SEED = 32'h996701c4;

	localparam logic [1:0] K_NONE = 2'd0;
	localparam logic [1:0] K_FIXED = 2'd1;
	localparam logic [1:0] K_STORE = 2'd2;
	localparam logic [1:0] K_LOAD = 2'd3;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic op_valid_i = 1'b0;
	logic [31:0] reg1_i = 32'b0;
	logic [31:0] reg2_i = 32'b0;
	logic [31:0] pc_i = 32'b0;
	logic [31:0] imm_i = 32'b0;
	logic [31:0] csr_rdata_i = 32'b0;
	exu_pkg::alu_op_e alu_op_i = exu_pkg::ALU_ADD;
	exu_pkg::src1_sel_e src1_sel_i = exu_pkg::SRC1_ZERO;
	exu_pkg::src2_sel_e src2_sel_i = exu_pkg::SRC2_ZERO;
	exu_pkg::branch_e branch_i = exu_pkg::BR_NONE;
	exu_pkg::csr_op_e csr_op_i = exu_pkg::CSR_NONE;
	mem_pkg::load_e load_i = mem_pkg::LD_NONE;
	mem_pkg::store_e store_i = mem_pkg::ST_NONE;
	logic wd_i = 1'b0;
	logic [4:0] rd_i = 5'b0;
	logic mem_ack_i = 1'b0;
	logic [31:0] mem_rdata_i = 32'b0;

	logic wb_valid_o;
	logic wb_we_o;
	logic [4:0] wb_rd_o;
	logic [31:0] wb_data_o;
	logic csr_we_o;
	logic [31:0] csr_wdata_o;
	logic inst_valid_o;
	logic [31:0] inst_o;
	logic [31:0] inst_pc_o;
	logic mem_req_o;
	logic mem_we_o;
	logic [ADDR_WIDTH-1:0] mem_addr_o;
	logic [31:0] mem_wdata_o;
	logic [3:0] mem_wstrb_o;

	// word indexed memory model
	logic [31:0] mem_model [0:1023];
	logic [31:0] rng_op = SEED;
	logic [31:0] rng_mem = SEED ^ 32'h5bd1e995;
	logic busy = 1'b0;
	logic [2:0] wait_cnt = 3'd0;
	int req_age = 0;

	// expected values of the operation in flight
	logic [1:0] exp_kind = K_NONE;
	logic [31:0] exp_data = 32'b0;
	logic [31:0] exp_csr_wdata = 32'b0;
	exu_pkg::csr_op_e exp_csr = exu_pkg::CSR_NONE;
	logic [31:0] exp_pc = 32'b0;
	logic [9:0] exp_idx = 10'b0;
	logic exp_we = 1'b0;
	logic [4:0] exp_rd = 5'b0;
	string cur_name = "none";
	int lat = 0;
	int issued = 0;
	int retired = 0;
	int tests_failed = 0;
	int errors = 0;
	int errors_seen = 0;
	logic report_due = 1'b0;

	logic [31:0] fetch_word;
	logic [31:0] stored_word;

	assign fetch_word = mem_model[inst_pc_o[11:2]];
	assign stored_word = mem_model[exp_idx];

	backend_top #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.RESET_PC   (32'h0)
	) DUT (
		.clock       (clock),
		.reset       (reset),
		.op_valid_i  (op_valid_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.pc_i        (pc_i),
		.imm_i       (imm_i),
		.csr_rdata_i (csr_rdata_i),
		.alu_op_i    (alu_op_i),
		.src1_sel_i  (src1_sel_i),
		.src2_sel_i  (src2_sel_i),
		.branch_i    (branch_i),
		.csr_op_i    (csr_op_i),
		.load_i      (load_i),
		.store_i     (store_i),
		.wd_i        (wd_i),
		.rd_i        (rd_i),
		.wb_valid_o  (wb_valid_o),
		.wb_we_o     (wb_we_o),
		.wb_rd_o     (wb_rd_o),
		.wb_data_o   (wb_data_o),
		.csr_we_o    (csr_we_o),
		.csr_wdata_o (csr_wdata_o),
		.inst_valid_o (inst_valid_o),
		.inst_o      (inst_o),
		.inst_pc_o   (inst_pc_o),
		.mem_req_o   (mem_req_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_wstrb_o (mem_wstrb_o),
		.mem_ack_i   (mem_ack_i),
		.mem_rdata_i (mem_rdata_i)
	);

	initial begin
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_op = xorshift(rng_op);
		return rng_op;
	endfunction

	function automatic logic [31:0] fill_word(input int i);
		return (32'(i) * 32'h01000193) ^ 32'h6b43a9b5;
	endfunction

	// rv32i integer semantics
	function automatic logic [31:0] alu_ref(input exu_pkg::alu_op_e op,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			exu_pkg::ALU_ADD:  return a + b;
			exu_pkg::ALU_SUB:  return a - b;
			exu_pkg::ALU_AND:  return a & b;
			exu_pkg::ALU_OR:   return a | b;
			exu_pkg::ALU_XOR:  return a ^ b;
			exu_pkg::ALU_SLL:  return a << b[4:0];
			exu_pkg::ALU_SRL:  return a >> b[4:0];
			exu_pkg::ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
			exu_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exu_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			default:           return b;
		endcase
	endfunction

	function automatic logic branch_taken(input exu_pkg::branch_e br,
		input logic [31:0] a, input logic [31:0] b);
		case (br)
			exu_pkg::BR_BEQ:  return a == b;
			exu_pkg::BR_BNE:  return a != b;
			exu_pkg::BR_BLT:  return $signed(a) < $signed(b);
			exu_pkg::BR_BGE:  return $signed(a) >= $signed(b);
			exu_pkg::BR_BLTU: return a < b;
			exu_pkg::BR_BGEU: return a >= b;
			exu_pkg::BR_JUMP: return 1'b1;
			default:          return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] load_ref(input mem_pkg::load_e ld,
		input logic [31:0] w, input logic [1:0] off);
		logic [7:0] b;
		logic [15:0] h;
		b = w[{off, 3'b000} +: 8];
		h = off[1] ? w[31:16] : w[15:0];
		case (ld)
			mem_pkg::LD_LB:  return {{24{b[7]}}, b};
			mem_pkg::LD_LBU: return {24'b0, b};
			mem_pkg::LD_LH:  return {{16{h[15]}}, h};
			mem_pkg::LD_LHU: return {16'b0, h};
			default:         return w;
		endcase
	endfunction

	// old word with only the addressed lanes replaced
	function automatic logic [31:0] store_ref(input mem_pkg::store_e st,
		input logic [31:0] old, input logic [31:0] d, input logic [1:0] off);
		logic [31:0] r;
		r = old;
		if (st == mem_pkg::ST_SB)
			r[{off, 3'b000} +: 8] = d[7:0];
		else if (st == mem_pkg::ST_SH && off[1])
			r[31:16] = d[15:0];
		else if (st == mem_pkg::ST_SH)
			r[15:0] = d[15:0];
		else if (st == mem_pkg::ST_SW)
			r = d;
		return r;
	endfunction

	// scripted decoder issues one operation per delivered instruction
	task automatic issue_op(input int n);
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] imm;
		logic [31:0] crd;
		logic [31:0] rv;
		logic [31:0] pc;
		logic [31:0] addr;
		logic [31:0] tgt;
		logic [31:0] next_pc;
		logic [31:0] expect_v;
		logic [31:0] csr_expect;
		logic [1:0] kind;
		logic wd;
		string name;
		exu_pkg::alu_op_e op;
		exu_pkg::src1_sel_e s1;
		exu_pkg::src2_sel_e s2;
		exu_pkg::branch_e br;
		exu_pkg::csr_op_e cop;
		mem_pkg::load_e ld;
		mem_pkg::store_e st;

		r1 = next_rand();
		r2 = next_rand();
		imm = next_rand();
		crd = next_rand();
		rv = next_rand();
		pc = inst_pc_o;
		// code stays below 0x800
		// data lives in 16 words from 0x800
		tgt = {22'b0, rv[9:2], 2'b00};
		addr = 32'h800 | (rv & 32'h3c);
		op = exu_pkg::ALU_ADD;
		s1 = exu_pkg::SRC1_REG1;
		s2 = exu_pkg::SRC2_REG2;
		br = exu_pkg::BR_NONE;
		cop = exu_pkg::CSR_NONE;
		ld = mem_pkg::LD_NONE;
		st = mem_pkg::ST_NONE;
		wd = 1'b1;
		kind = K_FIXED;
		next_pc = pc + 32'd4;
		expect_v = 32'b0;
		csr_expect = 32'b0;
		name = "none";
		case (n % 16)
			0, 1: begin
				op = exu_pkg::alu_op_e'(4'(next_rand() % 32'd10));
				if (n % 16 == 1) begin
					s2 = exu_pkg::SRC2_IMM;
					expect_v = alu_ref(op, r1, imm);
				end else begin
					expect_v = alu_ref(op, r1, r2);
				end
				name = op.name();
			end
			2: begin
				s1 = exu_pkg::SRC1_ZERO;
				s2 = exu_pkg::SRC2_IMM;
				op = exu_pkg::ALU_COPY;
				expect_v = imm;
				name = "lui";
			end
			3: begin
				s1 = exu_pkg::SRC1_PC;
				s2 = exu_pkg::SRC2_IMM;
				expect_v = pc + imm;
				name = "auipc";
			end
			4, 5, 6, 7, 8, 9: begin
				br = exu_pkg::branch_e'(3'(n % 16 - 3));
				if (br == exu_pkg::BR_BEQ || br == exu_pkg::BR_BNE)
					op = exu_pkg::ALU_SUB;
				else if (br == exu_pkg::BR_BLT || br == exu_pkg::BR_BGE)
					op = exu_pkg::ALU_SLT;
				else
					op = exu_pkg::ALU_SLTU;
				if (rv[31])
					r2 = r1;
				imm = tgt - pc;
				wd = 1'b0;
				expect_v = alu_ref(op, r1, r2);
				if (branch_taken(br, r1, r2))
					next_pc = tgt;
				name = br.name();
			end
			10: begin
				br = exu_pkg::BR_JUMP;
				s1 = exu_pkg::SRC1_PC;
				s2 = exu_pkg::SRC2_FOUR;
				imm = tgt - pc;
				expect_v = pc + 32'd4;
				next_pc = tgt;
				name = "jal";
			end
			11: begin
				st = mem_pkg::store_e'(2'(32'd1 + next_rand() % 32'd3));
				if (st == mem_pkg::ST_SB)
					addr[1:0] = rv[1:0];
				else if (st == mem_pkg::ST_SH)
					addr[1] = rv[1];
				s2 = exu_pkg::SRC2_IMM;
				imm = addr - r1;
				wd = 1'b0;
				kind = K_STORE;
				expect_v = store_ref(st, mem_model[addr[11:2]], r2, addr[1:0]);
				name = st.name();
			end
			12, 15: begin
				ld = mem_pkg::load_e'(3'(32'd1 + next_rand() % 32'd5));
				if (ld == mem_pkg::LD_LB || ld == mem_pkg::LD_LBU)
					addr[1:0] = rv[1:0];
				else if (ld == mem_pkg::LD_LH || ld == mem_pkg::LD_LHU)
					addr[1] = rv[1];
				s2 = exu_pkg::SRC2_IMM;
				imm = addr - r1;
				kind = K_LOAD;
				expect_v = load_ref(ld, mem_model[addr[11:2]], addr[1:0]);
				name = ld.name();
			end
			default: begin
				s1 = exu_pkg::SRC1_CSR;
				s2 = exu_pkg::SRC2_ZERO;
				cop = (n % 16 == 13) ? exu_pkg::CSR_RW : exu_pkg::CSR_RS;
				expect_v = crd;
				csr_expect = (cop == exu_pkg::CSR_RW) ? r1 : (r1 | crd);
				name = cop.name();
			end
		endcase
		op_valid_i <= 1'b1;
		reg1_i <= r1;
		reg2_i <= r2;
		pc_i <= pc;
		imm_i <= imm;
		csr_rdata_i <= crd;
		alu_op_i <= op;
		src1_sel_i <= s1;
		src2_sel_i <= s2;
		branch_i <= br;
		csr_op_i <= cop;
		load_i <= ld;
		store_i <= st;
		wd_i <= wd;
		rd_i <= rv[14:10];
		exp_kind <= kind;
		exp_data <= expect_v;
		exp_csr <= cop;
		exp_csr_wdata <= csr_expect;
		exp_pc <= next_pc;
		exp_idx <= addr[11:2];
		exp_we <= wd;
		exp_rd <= rv[14:10];
		cur_name <= name;
		issued <= issued + 1;
	endtask

	always @(posedge clock) begin
		op_valid_i <= 1'b0;
		if (!reset && inst_valid_o && issued < NUM_OPS)
			issue_op(issued);
	end

	// memory answers after 1 to 4 cycles
	always @(posedge clock) begin : respond
		int i;
		mem_ack_i <= 1'b0;
		if (reset) begin
			busy <= 1'b0;
			wait_cnt <= 3'd0;
			for (i = 0; i < 1024; i++)
				mem_model[i] <= fill_word(i);
		end else if (busy) begin
			if (wait_cnt <= 3'd1) begin
				mem_ack_i <= 1'b1;
				mem_rdata_i <= mem_model[mem_addr_o[11:2]];
				busy <= 1'b0;
				for (i = 0; i < 4; i++)
					if (mem_we_o && mem_wstrb_o[i])
						mem_model[mem_addr_o[11:2]][i*8 +: 8] <= mem_wdata_o[i*8 +: 8];
			end else begin
				wait_cnt <= wait_cnt - 3'd1;
			end
		end else if (mem_req_o && !mem_ack_i) begin
			rng_mem = xorshift(rng_mem);
			busy <= 1'b1;
			wait_cnt <= 3'(rng_mem[1:0]) + 3'd1;
		end
	end

	always @(posedge clock) begin
		if (reset || !mem_req_o || mem_ack_i)
			req_age <= 0;
		else
			req_age <= req_age + 1;
		if (op_valid_i)
			lat <= 1;
		else if (lat < 1000)
			lat <= lat + 1;
	end

	a_fixed_data: assert property (@(posedge clock) disable iff (reset)
		wb_valid_o && exp_kind == K_FIXED |-> wb_data_o == exp_data)
		else begin
			$display("Mismatch %s: expected %h, actual %h", cur_name, exp_data,
				$sampled(wb_data_o));
			errors++;
		end

	a_fixed_latency: assert property (@(posedge clock) disable iff (reset)
		wb_valid_o && exp_kind == K_FIXED |-> lat == 2)
		else begin
			$display("Mismatch %s latency: expected 2, actual %0d", cur_name, $sampled(lat));
			errors++;
		end

	a_wb_dest: assert property (@(posedge clock) disable iff (reset)
		wb_valid_o |-> wb_we_o == exp_we && wb_rd_o == exp_rd)
		else begin
			$display("Mismatch %s destination: expected we %b rd %0d, actual we %b rd %0d",
				cur_name, exp_we, exp_rd, $sampled(wb_we_o), $sampled(wb_rd_o));
			errors++;
		end

	a_load_data: assert property (@(posedge clock) disable iff (reset)
		wb_valid_o && exp_kind == K_LOAD |-> wb_data_o == exp_data)
		else begin
			$display("Mismatch %s: expected %h, actual %h", cur_name, exp_data,
				$sampled(wb_data_o));
			errors++;
		end

	a_store_word: assert property (@(posedge clock) disable iff (reset)
		wb_valid_o && exp_kind == K_STORE |-> stored_word == exp_data)
		else begin
			$display("Mismatch %s: expected %h, actual %h", cur_name, exp_data,
				$sampled(stored_word));
			errors++;
		end

	a_csr_data: assert property (@(posedge clock) disable iff (reset)
		wb_valid_o && exp_csr != exu_pkg::CSR_NONE |-> csr_wdata_o == exp_csr_wdata)
		else begin
			$display("Mismatch %s csr data: expected %h, actual %h", cur_name, exp_csr_wdata,
				$sampled(csr_wdata_o));
			errors++;
		end

	a_csr_write: assert property (@(posedge clock) disable iff (reset)
		wb_valid_o && exp_csr != exu_pkg::CSR_NONE |-> csr_we_o)
		else begin
			$display("csr_we_o stayed low at writeback of %s", cur_name);
			errors++;
		end

	a_csr_quiet: assert property (@(posedge clock) disable iff (reset)
		csr_we_o |-> wb_valid_o && exp_csr != exu_pkg::CSR_NONE)
		else begin
			$display("csr_we_o raised during %s, which is not a CSR operation", cur_name);
			errors++;
		end

	// next pc follows the branch outcome of the previous operation
	a_fetch_pc: assert property (@(posedge clock) disable iff (reset)
		inst_valid_o |-> inst_pc_o == exp_pc)
		else begin
			$display("Mismatch fetch pc after %s: expected %h, actual %h", cur_name, exp_pc,
				$sampled(inst_pc_o));
			errors++;
		end

	a_fetch_word: assert property (@(posedge clock) disable iff (reset)
		inst_valid_o |-> inst_o == fetch_word)
		else begin
			$display("Mismatch fetch word at %h: expected %h, actual %h", $sampled(inst_pc_o),
				$sampled(fetch_word), $sampled(inst_o));
			errors++;
		end

	a_bus_wait: assert property (@(posedge clock) disable iff (reset)
		mem_req_o |-> req_age < 20)
		else begin
			$display("memory request at %h waited 20 cycles without an acknowledge",
				$sampled(mem_addr_o));
			errors++;
		end

	// one line per retired operation a cycle after its writeback
	always @(posedge clock) begin
		report_due <= wb_valid_o && !reset;
		if (report_due) begin
			if (errors == errors_seen) begin
				$display("test %0d %s: ok", retired + 1, cur_name);
			end else begin
				$display("test %0d %s: failed", retired + 1, cur_name);
				tests_failed <= tests_failed + 1;
			end
			errors_seen <= errors;
			retired <= retired + 1;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: %0d of %0d operations retired after %0d cycles", retired, NUM_OPS,
			cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		while (retired < NUM_OPS)
			@(posedge clock);
		repeat (4) @(posedge clock);
		$display("%0d tests run, %0d failed, %0d check errors", retired, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: common/exu_pkg.sv
// execute stage encodings
`default_nettype none

package exu_pkg;

	// alu operation, selected by the decoder
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_COPY
	} alu_op_e;

	typedef enum logic [1:0] {
		SRC1_ZERO,
		SRC1_REG1,
		SRC1_PC,
		SRC1_CSR
	} src1_sel_e;

	typedef enum logic [1:0] {
		SRC2_ZERO,
		SRC2_REG2,
		SRC2_IMM,
		SRC2_FOUR
	} src2_sel_e;

	// signedness of blt/bltu comes from the alu op
	typedef enum logic [2:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU,
		BR_JUMP
	} branch_e;

	typedef enum logic [1:0] {
		CSR_NONE,
		CSR_RW,
		CSR_RS
	} csr_op_e;

endpackage

`default_nettype wire

// File: common/mem_pkg.sv
// memory side encodings
`default_nettype none

package mem_pkg;

	typedef enum logic [2:0] {
		LD_NONE,
		LD_LB,
		LD_LH,
		LD_LW,
		LD_LBU,
		LD_LHU
	} load_e;

	typedef enum logic [1:0] {
		ST_NONE,
		ST_SB,
		ST_SH,
		ST_SW
	} store_e;

	// current owner of the shared bus
	typedef enum logic {
		GNT_FETCH,
		GNT_LSU
	} grant_e;

endpackage

`default_nettype wire

// File: exu/exu_alu.sv
// integer alu
`timescale 1ns/1ns
`default_nettype none

module exu_alu (
	input wire [31:0] a_i,
	input wire [31:0] b_i,
	input wire exu_pkg::alu_op_e op_i,
	output logic [31:0] result_o,
	output logic less_o,
	output logic zero_o
);

	logic less_s;
	logic less_u;

	assign less_s = $signed(a_i) < $signed(b_i);
	assign less_u = a_i < b_i;

	// unsigned compare only when the op asks for it
	assign less_o = (op_i == exu_pkg::ALU_SLTU) ? less_u : less_s;

	always_comb begin
		case (op_i)
			exu_pkg::ALU_ADD:  result_o = a_i + b_i;
			exu_pkg::ALU_SUB:  result_o = a_i - b_i;
			exu_pkg::ALU_AND:  result_o = a_i & b_i;
			exu_pkg::ALU_OR:   result_o = a_i | b_i;
			exu_pkg::ALU_XOR:  result_o = a_i ^ b_i;
			exu_pkg::ALU_SLL:  result_o = a_i << b_i[4:0];
			exu_pkg::ALU_SRL:  result_o = a_i >> b_i[4:0];
			exu_pkg::ALU_SRA:  result_o = $signed(a_i) >>> b_i[4:0];
			exu_pkg::ALU_SLT:  result_o = {31'b0, less_s};
			exu_pkg::ALU_SLTU: result_o = {31'b0, less_u};
			exu_pkg::ALU_COPY: result_o = b_i;
			default:           result_o = a_i + b_i;
		endcase
	end

	// beq/bne look at a subtraction result
	assign zero_o = (result_o == 32'b0);

endmodule

`default_nettype wire

// File: exu/exu_stage.sv
// execute stage
`timescale 1ns/1ns
`default_nettype none

module exu_stage (
	input wire clock,
	input wire reset,
	input wire op_valid_i,
	input wire [31:0] reg1_i,
	input wire [31:0] reg2_i,
	input wire [31:0] pc_i,
	input wire [31:0] imm_i,
	input wire [31:0] csr_rdata_i,
	input wire exu_pkg::alu_op_e alu_op_i,
	input wire exu_pkg::src1_sel_e src1_sel_i,
	input wire exu_pkg::src2_sel_e src2_sel_i,
	input wire exu_pkg::branch_e branch_i,
	input wire exu_pkg::csr_op_e csr_op_i,
	input wire mem_pkg::load_e load_i,
	input wire mem_pkg::store_e store_i,
	input wire wd_i,
	input wire [4:0] rd_i,
	input wire lsu_done_i,
	input wire [31:0] lsu_rdata_i,
	output logic lsu_start_o,
	output logic [31:0] lsu_addr_o,
	output logic [31:0] lsu_wdata_o,
	output mem_pkg::load_e lsu_load_o,
	output mem_pkg::store_e lsu_store_o,
	output logic redirect_o,
	output logic [31:0] redirect_pc_o,
	output logic wb_valid_o,
	output logic wb_we_o,
	output logic [4:0] wb_rd_o,
	output logic [31:0] wb_data_o,
	output logic csr_we_o,
	output logic [31:0] csr_wdata_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_EXEC,
		S_MEM,
		S_WB
	} state_e;

	state_e state_q;

	// operation held from op_valid_i until writeback
	exu_pkg::alu_op_e alu_op_q;
	exu_pkg::src1_sel_e src1_q;
	exu_pkg::src2_sel_e src2_q;
	exu_pkg::branch_e branch_q;
	exu_pkg::csr_op_e csr_op_q;
	mem_pkg::load_e load_q;
	mem_pkg::store_e store_q;
	logic wd_q;
	logic [4:0] rd_q;
	logic [31:0] reg1_q;
	logic [31:0] reg2_q;
	logic [31:0] pc_q;
	logic [31:0] imm_q;
	logic [31:0] csr_rdata_q;
	logic [31:0] result_q;

	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic alu_less;
	logic alu_zero;
	logic taken;
	logic is_mem;

	always_comb begin
		case (src1_q)
			exu_pkg::SRC1_REG1: alu_a = reg1_q;
			exu_pkg::SRC1_PC:   alu_a = pc_q;
			exu_pkg::SRC1_CSR:  alu_a = csr_rdata_q;
			default:            alu_a = 32'b0;
		endcase
		case (src2_q)
			exu_pkg::SRC2_REG2: alu_b = reg2_q;
			exu_pkg::SRC2_IMM:  alu_b = imm_q;
			exu_pkg::SRC2_FOUR: alu_b = 32'd4;
			default:            alu_b = 32'b0;
		endcase
	end

	exu_alu u_alu (
		.a_i      (alu_a),
		.b_i      (alu_b),
		.op_i     (alu_op_q),
		.result_o (alu_result),
		.less_o   (alu_less),
		.zero_o   (alu_zero)
	);

	always_comb begin
		case (branch_q)
			exu_pkg::BR_BEQ:  taken = alu_zero;
			exu_pkg::BR_BNE:  taken = !alu_zero;
			exu_pkg::BR_BLT:  taken = alu_less;
			exu_pkg::BR_BGE:  taken = !alu_less;
			exu_pkg::BR_BLTU: taken = alu_less;
			exu_pkg::BR_BGEU: taken = !alu_less;
			exu_pkg::BR_JUMP: taken = 1'b1;
			default:          taken = 1'b0;
		endcase
		case (csr_op_q)
			exu_pkg::CSR_RW: csr_wdata_o = reg1_q;
			exu_pkg::CSR_RS: csr_wdata_o = reg1_q | csr_rdata_q;
			default:         csr_wdata_o = 32'b0;
		endcase
	end

	assign is_mem = (load_q != mem_pkg::LD_NONE) || (store_q != mem_pkg::ST_NONE);

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: if (op_valid_i) state_q <= S_EXEC;
				S_EXEC: state_q <= is_mem ? S_MEM : S_WB;
				S_MEM:  if (lsu_done_i) state_q <= S_WB;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (op_valid_i && state_q == S_IDLE) begin
			alu_op_q <= alu_op_i;
			src1_q <= src1_sel_i;
			src2_q <= src2_sel_i;
			branch_q <= branch_i;
			csr_op_q <= csr_op_i;
			load_q <= load_i;
			store_q <= store_i;
			wd_q <= wd_i;
			rd_q <= rd_i;
			reg1_q <= reg1_i;
			reg2_q <= reg2_i;
			pc_q <= pc_i;
			imm_q <= imm_i;
			csr_rdata_q <= csr_rdata_i;
		end
		if (state_q == S_EXEC)
			result_q <= alu_result;
		// loads replace the address with the loaded word
		if (state_q == S_MEM && lsu_done_i && load_q != mem_pkg::LD_NONE)
			result_q <= lsu_rdata_i;
	end

	// address is reg1 + imm through the alu
	assign lsu_start_o = (state_q == S_EXEC) && is_mem;
	assign lsu_addr_o = alu_result;
	assign lsu_wdata_o = reg2_q;
	assign lsu_load_o = load_q;
	assign lsu_store_o = store_q;

	assign wb_valid_o = (state_q == S_WB);
	assign wb_we_o = wd_q;
	assign wb_rd_o = rd_q;
	assign wb_data_o = result_q;
	assign csr_we_o = wb_valid_o && (csr_op_q != exu_pkg::CSR_NONE);
	assign redirect_o = wb_valid_o && taken;
	assign redirect_pc_o = pc_q + imm_q;

	// the decoder waits for writeback before the next op
	a_op_in_idle: assert property (@(posedge clock) disable iff (reset)
		op_valid_i |-> state_q == S_IDLE);

endmodule

`default_nettype wire

// File: flist.f
common/exu_pkg.sv
common/mem_pkg.sv
exu/exu_alu.sv
exu/exu_stage.sv
mem/mem_lsu.sv
mem/mem_arbiter.sv
src/fetch_unit.sv
src/backend_top.sv
bench/backend_tb.sv

// File: mem/mem_arbiter.sv
// round-robin bus arbiter
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter #(
	parameter int ADDR_WIDTH = 12
) (
	input wire clock,
	input wire reset,
	input wire f_req_i,
	input wire [ADDR_WIDTH-1:0] f_addr_i,
	output logic f_ack_o,
	input wire l_req_i,
	input wire l_we_i,
	input wire [ADDR_WIDTH-1:0] l_addr_i,
	input wire [31:0] l_wdata_i,
	input wire [3:0] l_wstrb_i,
	output logic l_ack_o,
	output logic mem_req_o,
	output logic mem_we_o,
	output logic [ADDR_WIDTH-1:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [3:0] mem_wstrb_o,
	input wire mem_ack_i
);

	mem_pkg::grant_e owner_q;
	mem_pkg::grant_e last_q;
	mem_pkg::grant_e pick;
	logic lock_q;
	logic sel_lsu;

	// on contention the side not served last wins
	always_comb begin
		if (f_req_i && l_req_i) begin
			if (last_q == mem_pkg::GNT_FETCH)
				pick = mem_pkg::GNT_LSU;
			else
				pick = mem_pkg::GNT_FETCH;
		end else if (l_req_i) begin
			pick = mem_pkg::GNT_LSU;
		end else begin
			pick = mem_pkg::GNT_FETCH;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lock_q <= 1'b0;
			owner_q <= mem_pkg::GNT_FETCH;
			last_q <= mem_pkg::GNT_LSU;
		end else if (!lock_q) begin
			if (f_req_i || l_req_i) begin
				lock_q <= 1'b1;
				owner_q <= pick;
			end
		end else if (mem_ack_i) begin
			lock_q <= 1'b0;
			last_q <= owner_q;
		end
	end

	assign sel_lsu = (owner_q == mem_pkg::GNT_LSU);

	assign mem_req_o = lock_q;
	assign mem_we_o = sel_lsu && l_we_i;
	assign mem_addr_o = sel_lsu ? l_addr_i : f_addr_i;
	assign mem_wdata_o = sel_lsu ? l_wdata_i : 32'b0;
	assign mem_wstrb_o = sel_lsu ? l_wstrb_i : 4'b0000;

	assign f_ack_o = lock_q && mem_ack_i && !sel_lsu;
	assign l_ack_o = lock_q && mem_ack_i && sel_lsu;

	a_ack_onehot: assert property (@(posedge clock) disable iff (reset)
		!(f_ack_o && l_ack_o));

	// a granted requester keeps asking until its ack
	a_owner_holds: assert property (@(posedge clock) disable iff (reset)
		lock_q |-> (sel_lsu ? l_req_i : f_req_i));

endmodule

`default_nettype wire

// File: mem/mem_lsu.sv
// load/store unit
`timescale 1ns/1ns
`default_nettype none

module mem_lsu #(
	parameter int ADDR_WIDTH = 12
) (
	input wire clock,
	input wire reset,
	input wire start_i,
	input wire [ADDR_WIDTH-1:0] addr_i,
	input wire [31:0] wdata_i,
	input wire mem_pkg::load_e load_i,
	input wire mem_pkg::store_e store_i,
	output logic req_o,
	output logic we_o,
	output logic [ADDR_WIDTH-1:0] addr_o,
	output logic [31:0] wdata_o,
	output logic [3:0] wstrb_o,
	input wire ack_i,
	input wire [31:0] rdata_i,
	output logic done_o,
	output logic [31:0] rdata_o
);

	mem_pkg::load_e load_q;
	logic [1:0] off_q;
	logic [31:0] shifted;
	logic [31:0] load_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			req_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				req_o <= 1'b1;
			end else if (ack_i) begin
				req_o <= 1'b0;
				done_o <= 1'b1;
			end
		end
	end

	// bus sees a word address, lanes picked by the strobes
	always_ff @(posedge clock) begin
		if (start_i) begin
			load_q <= load_i;
			off_q <= addr_i[1:0];
			addr_o <= {addr_i[ADDR_WIDTH-1:2], 2'b00};
			we_o <= (store_i != mem_pkg::ST_NONE);
			case (store_i)
				mem_pkg::ST_SB: begin
					wdata_o <= {4{wdata_i[7:0]}};
					wstrb_o <= 4'b0001 << addr_i[1:0];
				end
				mem_pkg::ST_SH: begin
					wdata_o <= {2{wdata_i[15:0]}};
					wstrb_o <= addr_i[1] ? 4'b1100 : 4'b0011;
				end
				mem_pkg::ST_SW: begin
					wdata_o <= wdata_i;
					wstrb_o <= 4'b1111;
				end
				default: begin
					wdata_o <= wdata_i;
					wstrb_o <= 4'b0000;
				end
			endcase
		end
		if (ack_i)
			rdata_o <= load_data;
	end

	// addressed byte moved down to lane zero
	assign shifted = rdata_i >> {off_q, 3'b000};

	always_comb begin
		case (load_q)
			mem_pkg::LD_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
			mem_pkg::LD_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
			mem_pkg::LD_LBU: load_data = {24'b0, shifted[7:0]};
			mem_pkg::LD_LHU: load_data = {16'b0, shifted[15:0]};
			default:         load_data = rdata_i;
		endcase
	end

	a_req_stable: assert property (@(posedge clock) disable iff (reset)
		req_o && !ack_i |=> req_o && $stable(addr_o) && $stable(wdata_o)
			&& $stable(wstrb_o) && $stable(we_o));

	// execute only starts an access while the unit is free
	a_start_idle: assert property (@(posedge clock) disable iff (reset)
		start_i |-> !req_o);

endmodule

`default_nettype wire

// File: src/backend_top.sv
// execute back end top level
`timescale 1ns/1ns
`default_nettype none

module backend_top #(
	parameter int ADDR_WIDTH = 12,
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input wire clock,
	input wire reset,
	input wire op_valid_i,
	input wire [31:0] reg1_i,
	input wire [31:0] reg2_i,
	input wire [31:0] pc_i,
	input wire [31:0] imm_i,
	input wire [31:0] csr_rdata_i,
	input wire exu_pkg::alu_op_e alu_op_i,
	input wire exu_pkg::src1_sel_e src1_sel_i,
	input wire exu_pkg::src2_sel_e src2_sel_i,
	input wire exu_pkg::branch_e branch_i,
	input wire exu_pkg::csr_op_e csr_op_i,
	input wire mem_pkg::load_e load_i,
	input wire mem_pkg::store_e store_i,
	input wire wd_i,
	input wire [4:0] rd_i,
	output logic wb_valid_o,
	output logic wb_we_o,
	output logic [4:0] wb_rd_o,
	output logic [31:0] wb_data_o,
	output logic csr_we_o,
	output logic [31:0] csr_wdata_o,
	output logic inst_valid_o,
	output logic [31:0] inst_o,
	output logic [31:0] inst_pc_o,
	output logic mem_req_o,
	output logic mem_we_o,
	output logic [ADDR_WIDTH-1:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [3:0] mem_wstrb_o,
	input wire mem_ack_i,
	input wire [31:0] mem_rdata_i
);

	logic lsu_start;
	logic [31:0] lsu_addr;
	logic [31:0] lsu_wdata;
	mem_pkg::load_e lsu_load;
	mem_pkg::store_e lsu_store;
	logic lsu_done;
	logic [31:0] lsu_rdata;
	logic redirect;
	logic [31:0] redirect_pc;
	logic f_req;
	logic [ADDR_WIDTH-1:0] f_addr;
	logic f_ack;
	logic l_req;
	logic l_we;
	logic [ADDR_WIDTH-1:0] l_addr;
	logic [31:0] l_wdata;
	logic [3:0] l_wstrb;
	logic l_ack;

	// retire is the writeback pulse itself
	fetch_unit #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.RESET_PC   (RESET_PC)
	) u_fetch (
		.clock         (clock),
		.reset         (reset),
		.retire_i      (wb_valid_o),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc[ADDR_WIDTH-1:0]),
		.req_o         (f_req),
		.addr_o        (f_addr),
		.ack_i         (f_ack),
		.rdata_i       (mem_rdata_i),
		.inst_valid_o  (inst_valid_o),
		.inst_o        (inst_o),
		.inst_pc_o     (inst_pc_o)
	);

	exu_stage u_exu (
		.clock         (clock),
		.reset         (reset),
		.op_valid_i    (op_valid_i),
		.reg1_i        (reg1_i),
		.reg2_i        (reg2_i),
		.pc_i          (pc_i),
		.imm_i         (imm_i),
		.csr_rdata_i   (csr_rdata_i),
		.alu_op_i      (alu_op_i),
		.src1_sel_i    (src1_sel_i),
		.src2_sel_i    (src2_sel_i),
		.branch_i      (branch_i),
		.csr_op_i      (csr_op_i),
		.load_i        (load_i),
		.store_i       (store_i),
		.wd_i          (wd_i),
		.rd_i          (rd_i),
		.lsu_done_i    (lsu_done),
		.lsu_rdata_i   (lsu_rdata),
		.lsu_start_o   (lsu_start),
		.lsu_addr_o    (lsu_addr),
		.lsu_wdata_o   (lsu_wdata),
		.lsu_load_o    (lsu_load),
		.lsu_store_o   (lsu_store),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc),
		.wb_valid_o    (wb_valid_o),
		.wb_we_o       (wb_we_o),
		.wb_rd_o       (wb_rd_o),
		.wb_data_o     (wb_data_o),
		.csr_we_o      (csr_we_o),
		.csr_wdata_o   (csr_wdata_o)
	);

	mem_lsu #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_lsu (
		.clock   (clock),
		.reset   (reset),
		.start_i (lsu_start),
		.addr_i  (lsu_addr[ADDR_WIDTH-1:0]),
		.wdata_i (lsu_wdata),
		.load_i  (lsu_load),
		.store_i (lsu_store),
		.req_o   (l_req),
		.we_o    (l_we),
		.addr_o  (l_addr),
		.wdata_o (l_wdata),
		.wstrb_o (l_wstrb),
		.ack_i   (l_ack),
		.rdata_i (mem_rdata_i),
		.done_o  (lsu_done),
		.rdata_o (lsu_rdata)
	);

	mem_arbiter #(
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_arb (
		.clock       (clock),
		.reset       (reset),
		.f_req_i     (f_req),
		.f_addr_i    (f_addr),
		.f_ack_o     (f_ack),
		.l_req_i     (l_req),
		.l_we_i      (l_we),
		.l_addr_i    (l_addr),
		.l_wdata_i   (l_wdata),
		.l_wstrb_i   (l_wstrb),
		.l_ack_o     (l_ack),
		.mem_req_o   (mem_req_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_wstrb_o (mem_wstrb_o),
		.mem_ack_i   (mem_ack_i)
	);

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
// instruction fetch with one-word prefetch
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
	parameter int ADDR_WIDTH = 12,
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input wire clock,
	input wire reset,
	input wire retire_i,
	input wire redirect_i,
	input wire [ADDR_WIDTH-1:0] redirect_pc_i,
	output logic req_o,
	output logic [ADDR_WIDTH-1:0] addr_o,
	input wire ack_i,
	input wire [31:0] rdata_i,
	output logic inst_valid_o,
	output logic [31:0] inst_o,
	output logic [31:0] inst_pc_o
);

	// addr_q always points at the next word to fetch
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [ADDR_WIDTH-1:0] target_q;
	logic [ADDR_WIDTH-1:0] buf_pc_q;
	logic [ADDR_WIDTH-1:0] pc_sel;
	logic [31:0] buf_q;
	logic buf_full_q;
	logic need_q;
	logic show_q;
	logic drop_q;
	logic forward;

	// word goes straight out when the decoder is already waiting
	assign forward = ack_i && need_q && !drop_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			req_o <= 1'b1;
			addr_q <= RESET_PC[ADDR_WIDTH-1:0];
			need_q <= 1'b1;
			buf_full_q <= 1'b0;
			show_q <= 1'b0;
			drop_q <= 1'b0;
		end else begin
			show_q <= 1'b0;
			if (ack_i && drop_q) begin
				drop_q <= 1'b0;
				addr_q <= target_q;
			end else if (ack_i) begin
				buf_pc_q <= addr_q;
				buf_q <= rdata_i;
				addr_q <= addr_q + ADDR_WIDTH'(4);
				buf_full_q <= !need_q;
				need_q <= 1'b0;
				req_o <= need_q;
			end
			if (redirect_i) begin
				need_q <= 1'b1;
				buf_full_q <= 1'b0;
				target_q <= redirect_pc_i;
				if (req_o && !ack_i) begin
					drop_q <= 1'b1;
				end else begin
					addr_q <= redirect_pc_i;
					req_o <= 1'b1;
				end
			end else if (retire_i) begin
				if (buf_full_q || (ack_i && !drop_q)) begin
					show_q <= 1'b1;
					buf_full_q <= 1'b0;
					req_o <= 1'b1;
				end else begin
					need_q <= 1'b1;
				end
			end
		end
	end

	assign addr_o = addr_q;
	assign inst_valid_o = show_q || forward;
	assign inst_o = show_q ? buf_q : rdata_i;
	assign pc_sel = show_q ? buf_pc_q : addr_q;
	assign inst_pc_o = {{(32 - ADDR_WIDTH){1'b0}}, pc_sel};

	a_redirect_retires: assert property (@(posedge clock) disable iff (reset)
		redirect_i |-> retire_i);

endmodule

`default_nettype wire
